//--- dv/bp_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_cfg.svh"

// Watches the front end ports and runs its own model of the table and the PC.
// Model state moves on the rising edge, comparisons happen on the falling edge.
module bp_checker (
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  logic                  i_stall,
        input  logic                  i_clear,
        input  logic                  i_res_valid,
        input  logic [`BP_ADDR_W-1:0] i_res_src,
        input  logic [`BP_ADDR_W-1:0] i_res_dest,
        input  logic                  i_res_taken,
        input  logic [1:0]            i_res_pred_state,
        input  logic [`BP_ADDR_W-1:0] i_pc,
        input  logic                  i_clear_from_btb,
        input  logic [`BP_ADDR_W-1:0] i_pc_from_btb,
        input  logic [1:0]            i_branch_state,
        input  logic                  i_res_redirect,
        input  logic [127:0]          i_test_name,
        input  logic                  i_exp_redirect,
        output int                    o_errors,
        output int                    o_checks
);

localparam int IDX_W = $clog2(`BP_ENTRIES);

// Model of the table.
logic                  tbl_valid  [`BP_ENTRIES];
logic [`BP_ADDR_W-1:0] tbl_tag    [`BP_ENTRIES];
logic [`BP_ADDR_W-1:0] tbl_target [`BP_ENTRIES];
logic [1:0]            tbl_state  [`BP_ENTRIES];

// Model of the pipeline registers.
logic                  m_fb_wr, m_redir, m_pend, m_rd_valid, m_pred;
logic [`BP_ADDR_W-1:0] m_fb_src, m_fb_dest, m_redir_target, m_pend_target;
logic [`BP_ADDR_W-1:0] m_pc, m_pc_del, m_rd_tag, m_rd_target, m_pred_target;
logic [1:0]            m_fb_state, m_rd_state, m_pred_state;
logic                  m_live = 1'b0;
logic                  m_flag_due, m_flag;
logic [127:0]          m_name;

////////////////////////////////////////
// Rules
////////////////////////////////////////

// Direct mapped index, just above the offset bit.
function automatic int unsigned index_of(input logic [`BP_ADDR_W-1:0] a);
        return (a >> 1) % `BP_ENTRIES;
endfunction

// Everything above the index.
function automatic logic [`BP_ADDR_W-1:0] tag_of(input logic [`BP_ADDR_W-1:0] a);
        return a >> (IDX_W + 1);
endfunction

// Right guess saturates on its own side, wrong guess lands on the weak state.
function automatic logic [1:0] counter_update(input logic [1:0] s, input logic wrong);
        if (wrong)
                return s[0] ? 2'd2 : 2'd1;
        return s[1] ? 2'd3 : 2'd0;
endfunction

task automatic compare_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        o_checks++;
        if (exp !== act)
        begin
                o_errors++;
                $display("Error %0s: %0s expected %h actual %h", m_name, what, exp, act);
        end
endtask

initial
begin
        o_errors = 0;
        o_checks = 0;
end

////////////////////////////////////////
// Model update
////////////////////////////////////////

always @(posedge i_clk)
begin
        logic wrong;
        logic hit;
        wrong = i_res_pred_state[1] != i_res_taken;
        // Stored tag checked against the address that was looked up.
        hit = m_rd_valid && (m_rd_tag == tag_of(m_pc_del));
        m_live     <= 1'b1;
        m_name     <= i_test_name;
        m_flag_due <= i_res_valid && !i_reset;
        m_flag     <= i_exp_redirect;
        if (i_reset)
        begin
                m_fb_wr      <= 1'b0;
                m_redir      <= 1'b0;
                m_pend       <= 1'b0;
                m_pc         <= '0;
                m_pc_del     <= '0;
                m_rd_valid   <= 1'b0;
                m_pred       <= 1'b0;
                m_pred_state <= 2'd0;
                for (int i = 0; i < `BP_ENTRIES; i++)
                        tbl_valid[i] <= 1'b0;
        end
        else
        begin
                // Resolver, one cycle behind its input.
                m_fb_wr <= i_res_valid;
                m_redir <= i_res_valid && wrong;
                if (i_res_valid)
                begin
                        m_fb_src       <= i_res_src;
                        m_fb_dest      <= i_res_dest;
                        m_fb_state     <= counter_update(i_res_pred_state, wrong);
                        m_redir_target <= i_res_taken ? i_res_dest : i_res_src + `BP_STEP;
                end
                // Training write. Reads in this same cycle still see old data.
                if (m_fb_wr)
                begin
                        tbl_tag[index_of(m_fb_src)]    <= tag_of(m_fb_src);
                        tbl_target[index_of(m_fb_src)] <= m_fb_dest;
                        tbl_state[index_of(m_fb_src)]  <= m_fb_state;
                end
                if (i_clear)
                        for (int i = 0; i < `BP_ENTRIES; i++)
                                tbl_valid[i] <= 1'b0;
                else if (m_fb_wr)
                        tbl_valid[index_of(m_fb_src)] <= 1'b1;
                // A resolver redirect that meets a stall waits for the stall to end.
                if (i_stall && m_redir)
                begin
                        m_pend        <= 1'b1;
                        m_pend_target <= m_redir_target;
                end
                else if (!i_stall)
                        m_pend <= 1'b0;
                // Fetch and lookup stages.
                if (!i_stall)
                begin
                        if (m_redir)
                                m_pc <= m_redir_target;
                        else if (m_pend)
                                m_pc <= m_pend_target;
                        else if (m_pred)
                                m_pc <= m_pred_target;
                        else
                                m_pc <= m_pc + `BP_STEP;
                        m_pc_del      <= m_pc;
                        m_rd_tag      <= tbl_tag[index_of(m_pc)];
                        m_rd_target   <= tbl_target[index_of(m_pc)];
                        m_rd_state    <= tbl_state[index_of(m_pc)];
                        m_pred_target <= m_rd_target;
                end
                if (i_clear)
                begin
                        m_rd_valid   <= 1'b0;
                        m_pred       <= 1'b0;
                        m_pred_state <= 2'd0;
                end
                else if (!i_stall)
                begin
                        m_rd_valid   <= tbl_valid[index_of(m_pc)];
                        m_pred       <= hit && m_rd_state[1];
                        m_pred_state <= hit ? m_rd_state : 2'd0;
                end
        end
end

////////////////////////////////////////
// Comparisons
////////////////////////////////////////

always @(negedge i_clk)
begin
        if (m_live)
        begin
                compare_value("o_pc", m_pc, i_pc);
                compare_value("o_clear_from_btb", m_pred, i_clear_from_btb);
                compare_value("o_branch_state", m_pred_state, i_branch_state);
                compare_value("o_res_redirect", m_redir, i_res_redirect);
                // Target only means something with the pulse.
                if (m_pred)
                        compare_value("o_pc_from_btb", m_pred_target, i_pc_from_btb);
                // Flag from the stimulus record.
                if (m_flag_due)
                        compare_value("expected redirect", m_flag, i_res_redirect);
        end
end

endmodule

`default_nettype wire

//--- dv/bp_stimulus.txt
# name cycles stall clear valid src dest taken pred_state exp_redirect (src, dest in hex)
# stall 2 draws a random stall each cycle; clear and valid apply to the first cycle only
reset_seq     20 0 0 0 00000000 00000000 0 0 0
train_snt      4 0 0 1 00000100 00000100 1 0 1
train_wnt      4 0 0 1 00000100 00000100 1 1 1
train_wt       4 0 0 1 00000100 00000100 1 2 0
train_st       4 0 0 1 00000100 00000100 1 3 0
train_st_nt    4 0 0 1 00000100 00000100 0 3 1
train_wt_nt    4 0 0 1 00000100 00000100 0 2 1
train_wnt_nt   4 0 0 1 00000100 00000100 0 1 0
pred_train     4 0 0 1 00000180 00000400 1 2 0
pred_hit      16 0 0 1 00000020 00000180 1 0 1
prio_jump      3 0 0 1 00000020 00000180 1 0 1
prio_both      8 0 0 1 00000060 00000500 1 1 1
clear_all      2 0 1 0 00000000 00000000 0 0 0
clear_miss    10 0 0 1 00000020 00000180 1 0 1
stall_train    4 0 0 1 00000180 00000600 1 3 0
stall_rand    40 2 0 1 00000020 00000180 1 1 1
stall_hold     5 1 0 0 00000000 00000000 0 0 0
drain         10 0 0 0 00000000 00000000 0 0 0

//--- dv/tb_bp_frontend.sv
`timescale 1ns/1ps
`default_nettype none

// Testbench for the branch prediction front end.
// Records from the stimulus file are driven on the falling edge.
module tb_bp_frontend;

logic                clk;
logic                reset;
logic                stall;
logic                clear;
logic                res_valid;
logic                res_taken;
bp_addr_pkg::addr_t  res_src;
bp_addr_pkg::addr_t  res_dest;
bp_pred_pkg::state_t res_pred_state;
bp_addr_pkg::addr_t  pc;
bp_addr_pkg::addr_t  pc_from_btb;
logic                clear_from_btb;
logic                res_redirect;
bp_pred_pkg::state_t branch_state;

logic [127:0]        test_name;
logic                exp_redirect;
int                  chk_errors;
int                  chk_checks;
int                  tb_errors;

// File reading.
int                  fd;
int                  fields;
int                  records;
int                  idle_wait;
logic [8*128-1:0]    line;
logic [127:0]        f_name;
int                  f_cycles, f_stall, f_clear, f_valid, f_taken, f_pred, f_exp;
logic [31:0]         f_src, f_dest;

bp_frontend dut (
        .i_clk            (clk),
        .i_reset          (reset),
        .i_stall          (stall),
        .i_clear          (clear),
        .i_res_valid      (res_valid),
        .i_res_src        (res_src),
        .i_res_dest       (res_dest),
        .i_res_taken      (res_taken),
        .i_res_pred_state (res_pred_state),
        .o_pc             (pc),
        .o_clear_from_btb (clear_from_btb),
        .o_pc_from_btb    (pc_from_btb),
        .o_branch_state   (branch_state),
        .o_res_redirect   (res_redirect)
);

bp_checker u_checker (
        .i_clk            (clk),
        .i_reset          (reset),
        .i_stall          (stall),
        .i_clear          (clear),
        .i_res_valid      (res_valid),
        .i_res_src        (res_src),
        .i_res_dest       (res_dest),
        .i_res_taken      (res_taken),
        .i_res_pred_state (res_pred_state),
        .i_pc             (pc),
        .i_clear_from_btb (clear_from_btb),
        .i_pc_from_btb    (pc_from_btb),
        .i_branch_state   (branch_state),
        .i_res_redirect   (res_redirect),
        .i_test_name      (test_name),
        .i_exp_redirect   (exp_redirect),
        .o_errors         (chk_errors),
        .o_checks         (chk_checks)
);

// 8 ns clock.
initial
begin
        clk = 1'b0;
        forever #4 clk = ~clk;
end

// One record. Stall holds for every cycle, clear and resolve only for the first.
task automatic drive_record(input logic [127:0] name, input int cycles, input int stall_mode,
                            input int clear_in, input int valid_in, input logic [31:0] src,
                            input logic [31:0] dest, input int taken_in, input int pred_in,
                            input int exp_in);
        for (int c = 0; c < cycles; c++)
        begin
                @(negedge clk);
                test_name      = name;
                stall          = (stall_mode == 2) ? (($urandom % 4) == 0) : (stall_mode != 0);
                clear          = (c == 0) && (clear_in != 0);
                res_valid      = (c == 0) && (valid_in != 0);
                res_src        = src;
                res_dest       = dest;
                res_taken      = taken_in != 0;
                res_pred_state = bp_pred_pkg::state_t'(pred_in);
                exp_redirect   = exp_in != 0;
        end
endtask

////////////////////////////////////////
// Main sequence
////////////////////////////////////////

initial
begin
        reset          = 1'b1;
        stall          = 1'b0;
        clear          = 1'b0;
        res_valid      = 1'b0;
        res_taken      = 1'b0;
        res_src        = '0;
        res_dest       = '0;
        res_pred_state = bp_pred_pkg::SNT;
        test_name      = "reset";
        exp_redirect   = 1'b0;
        tb_errors      = 0;
        records        = 0;
        void'($urandom(32'h1206598d));

        // Three cycles of reset.
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        fd = $fopen("dv/bp_stimulus.txt", "r");
        if (fd == 0)
        begin
                $display("Could not open the stimulus file dv/bp_stimulus.txt");
                tb_errors++;
        end
        else
        begin
                while (!$feof(fd))
                begin
                        line = '0;
                        if ($fgets(line, fd) == 0)
                                continue;
                        // Comment and blank lines do not give all ten fields.
                        fields = $sscanf(line, "%s %d %d %d %d %h %h %d %d %d", f_name,
                                         f_cycles, f_stall, f_clear, f_valid, f_src, f_dest,
                                         f_taken, f_pred, f_exp);
                        if (fields == 10)
                        begin
                                records++;
                                drive_record(f_name, f_cycles, f_stall, f_clear, f_valid,
                                             f_src, f_dest, f_taken, f_pred, f_exp);
                        end
                end
                $fclose(fd);
                if (records == 0)
                begin
                        $display("No stimulus records were read from the file");
                        tb_errors++;
                end
        end

        // Back to idle, then let pending pulses drain.
        drive_record("idle", 1, 0, 0, 0, 32'h0, 32'h0, 0, 0, 0);
        idle_wait = 0;
        while ((clear_from_btb || res_redirect) && idle_wait < 20)
        begin
                @(negedge clk);
                idle_wait++;
        end
        if (idle_wait >= 20)
        begin
                $display("Timed out waiting for the prediction pulses to go low");
                tb_errors++;
        end
        @(posedge clk);

        $display("Checks: %0d, checker errors: %0d, testbench errors: %0d",
                 chk_checks, chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0)
                $display("test passed");
        else
                $display("test failed");
        $finish;
end

endmodule

`default_nettype wire

//--- include/bp_cfg.svh
`ifndef BP_CFG_SVH
`define BP_CFG_SVH

// Number of branch target buffer entries.
// Must be a power of two.
`define BP_ENTRIES 64

// Width of a fetch address in bits.
`define BP_ADDR_W 32

// Fetch increment in bytes.
// Address LSB is always zero.
`define BP_STEP 2

`endif

//--- sources.f
+incdir+include
src/bp_pred_pkg.sv
src/bp_addr_pkg.sv
src/bp_fb_if.sv
src/btb_ram.sv
src/btb.sv
src/pc_sequencer.sv
src/branch_resolver.sv
src/bp_frontend.sv
dv/bp_checker.sv
dv/tb_bp_frontend.sv

//--- src/bp_addr_pkg.sv
`default_nettype none

`include "bp_cfg.svh"

// Fetch address layout and buffer entry layout.
// Compiled after bp_pred_pkg because the entry holds a counter state.
package bp_addr_pkg;

        // Index bits select one of the direct mapped entries.
        localparam int IDX_W = $clog2(`BP_ENTRIES);

        // Tag is whatever is left above the index and the offset bit.
        localparam int TAG_W = `BP_ADDR_W - IDX_W - 1;

        // Fetch address split for direct mapped lookup.
        typedef struct packed {
                logic [TAG_W-1:0] tag;
                logic [IDX_W-1:0] index;
                logic             offset;
        } addr_t;

        // One RAM word. State sits in the low bits.
        typedef struct packed {
                addr_t               target;
                logic [TAG_W-1:0]    tag;
                bp_pred_pkg::state_t state;
        } entry_t;

        // Raw RAM word width.
        localparam int ENTRY_W = $bits(entry_t);

endpackage

`default_nettype wire

//--- src/bp_fb_if.sv
`timescale 1ns/1ps
`default_nettype none

// Training path from the branch resolver into the buffer.
// Pulses are one cycle wide and never overlap.
interface bp_fb_if;

        // Prediction was right.
        logic                fb_ok;
        // Prediction was wrong.
        logic                fb_nok;
        // Branch instruction address.
        bp_addr_pkg::addr_t  fb_src;
        // Updated counter to store.
        bp_pred_pkg::state_t fb_state;
        // Branch destination address.
        bp_addr_pkg::addr_t  fb_dest;

        // Resolver side.
        modport source (output fb_ok, fb_nok, fb_src, fb_state, fb_dest);

        // Buffer side.
        modport sink (input fb_ok, fb_nok, fb_src, fb_state, fb_dest);

endinterface

`default_nettype wire

//--- src/bp_frontend.sv
`timescale 1ns/1ps
`default_nettype none

// Branch prediction front end.
// Sequencer, target buffer and resolver around one feedback link.
module bp_frontend (
        input  logic                i_clk,
        input  logic                i_reset,
        input  logic                i_stall,
        input  logic                i_clear,

        // Resolved branch from later stages.
        input  logic                i_res_valid,
        input  bp_addr_pkg::addr_t  i_res_src,
        input  bp_addr_pkg::addr_t  i_res_dest,
        input  logic                i_res_taken,
        input  bp_pred_pkg::state_t i_res_pred_state,

        // Fetch address.
        output bp_addr_pkg::addr_t  o_pc,

        // Prediction.
        output logic                o_clear_from_btb,
        output bp_addr_pkg::addr_t  o_pc_from_btb,
        output bp_pred_pkg::state_t o_branch_state,

        // Misprediction pulse.
        output logic                o_res_redirect
);

bp_addr_pkg::addr_t rd_addr_del;
bp_addr_pkg::addr_t res_target;

// Training link.
bp_fb_if fb ();

pc_sequencer u_pc_sequencer (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_stall        (i_stall),
        .i_btb_redirect (o_clear_from_btb),
        .i_btb_target   (o_pc_from_btb),
        .i_res_redirect (o_res_redirect),
        .i_res_target   (res_target),
        .o_rd_addr      (o_pc),
        .o_rd_addr_del  (rd_addr_del)
);

btb u_btb (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_stall          (i_stall),
        .i_clear          (i_clear),
        .fb               (fb.sink),
        .i_rd_addr        (o_pc),
        .i_rd_addr_del    (rd_addr_del),
        .o_clear_from_btb (o_clear_from_btb),
        .o_pc_from_btb    (o_pc_from_btb),
        .o_branch_state   (o_branch_state)
);

branch_resolver u_branch_resolver (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_res_valid      (i_res_valid),
        .i_res_src        (i_res_src),
        .i_res_dest       (i_res_dest),
        .i_res_taken      (i_res_taken),
        .i_res_pred_state (i_res_pred_state),
        .fb               (fb.source),
        .o_redirect       (o_res_redirect),
        .o_target         (res_target)
);

endmodule

`default_nettype wire

//--- src/bp_pred_pkg.sv
`default_nettype none

// Direction counter encoding and update rule.
package bp_pred_pkg;

        // Two bit saturating counter.
        typedef enum logic [1:0] {
                SNT = 2'd0,
                WNT = 2'd1,
                WT  = 2'd2,
                ST  = 2'd3
        } state_t;

        // Upper half of the counter predicts taken.
        function automatic logic is_taken(input state_t s);
                return (s == WT) || (s == ST);
        endfunction

        // Counter update after a branch resolves.
        function automatic state_t next_state(input state_t s, input logic nok);
                state_t ns;
                if (nok)
                begin
                        // Wrong guess. Step towards the other side.
                        case (s)
                        SNT: ns = WNT;
                        WNT: ns = WT;
                        WT:  ns = WNT;
                        ST:  ns = WT;
                        endcase
                end
                else
                begin
                        // Right guess. Reinforce.
                        case (s)
                        SNT, WNT: ns = SNT;
                        WT, ST:   ns = ST;
                        endcase
                end
                return ns;
        endfunction

endpackage

`default_nettype wire

//--- src/branch_resolver.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_cfg.svh"

// Checks resolved branches against their prediction.
// Trains the buffer and corrects the fetch PC one cycle later.
module branch_resolver (
        input  logic                i_clk,
        input  logic                i_reset,

        ////////////////////////////////////////
        // Resolved branch
        ////////////////////////////////////////

        input  logic                i_res_valid,
        input  bp_addr_pkg::addr_t  i_res_src,
        input  bp_addr_pkg::addr_t  i_res_dest,
        input  logic                i_res_taken,
        input  bp_pred_pkg::state_t i_res_pred_state,

        // Training path into the buffer.
        bp_fb_if.source             fb,

        // Corrective redirect.
        output logic                o_redirect,
        output bp_addr_pkg::addr_t  o_target
);

localparam bp_addr_pkg::addr_t STEP = `BP_STEP;

logic               mispredict;
bp_addr_pkg::addr_t fall_through;

// Direction disagreement is a misprediction.
assign mispredict = bp_pred_pkg::is_taken(i_res_pred_state) != i_res_taken;

// Next instruction after a not taken branch.
assign fall_through = bp_addr_pkg::addr_t'(i_res_src + STEP);

// Outcome pulses.
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                fb.fb_ok   <= 1'b0;
                fb.fb_nok  <= 1'b0;
                o_redirect <= 1'b0;
        end
        else
        begin
                fb.fb_ok   <= i_res_valid & ~mispredict;
                fb.fb_nok  <= i_res_valid & mispredict;
                o_redirect <= i_res_valid & mispredict;
        end
end

// Payload, captured with each resolution.
always_ff @(posedge i_clk)
begin
        if (i_res_valid)
        begin
                fb.fb_src   <= i_res_src;
                fb.fb_dest  <= i_res_dest;
                fb.fb_state <= bp_pred_pkg::next_state(i_res_pred_state, mispredict);
                o_target    <= i_res_taken ? i_res_dest : fall_through;
        end
end

endmodule

`default_nettype wire

//--- src/btb.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_cfg.svh"

// Direct mapped branch target buffer.
// Valid bits live in flops; tag, target and counter live in the RAM.
module btb (
        // Clock and reset.
        input  logic                i_clk,
        input  logic                i_reset,

        ////////////////////////////////////////
        // Pipeline controls
        ////////////////////////////////////////

        input  logic                i_stall,
        input  logic                i_clear,

        ////////////////////////////////////////
        // Training path
        ////////////////////////////////////////

        bp_fb_if.sink               fb,

        ////////////////////////////////////////
        // Lookup path
        ////////////////////////////////////////

        // Address being read this cycle.
        input  bp_addr_pkg::addr_t  i_rd_addr,
        // Address whose RAM data is on the read port.
        input  bp_addr_pkg::addr_t  i_rd_addr_del,

        // Redirect pulse and predicted target.
        output logic                o_clear_from_btb,
        output bp_addr_pkg::addr_t  o_pc_from_btb,

        // Counter of the looked up entry.
        output bp_pred_pkg::state_t o_branch_state
);

logic [`BP_ENTRIES-1:0] valid;
logic                   rd_valid;
logic                   mem_wr_en;
logic                   mem_rd_en;
logic                   tag_match;
logic                   hit;

bp_addr_pkg::entry_t    wr_data;
bp_addr_pkg::entry_t    rd_data;

// Any feedback trains the entry.
assign mem_wr_en = fb.fb_ok | fb.fb_nok;

// Lookups freeze with the pipeline.
assign mem_rd_en = ~i_stall;

// New entry. The resolver already computed the new counter.
assign wr_data.target = fb.fb_dest;
assign wr_data.tag    = fb.fb_src.tag;
assign wr_data.state  = fb.fb_state;

btb_ram #(
        .WIDTH     (bp_addr_pkg::ENTRY_W)
) u_btb_ram (
        .i_clk     (i_clk),
        .i_wr_en   (mem_wr_en),
        .i_wr_addr (fb.fb_src.index),
        .i_wr_data (wr_data),
        .i_rd_en   (mem_rd_en),
        .i_rd_addr (i_rd_addr.index),
        .o_rd_data (rd_data)
);

// Valid bits.
// Clear wins over a write in the same cycle.
always_ff @(posedge i_clk)
begin
        if (i_reset || i_clear)
                valid <= '0;
        else if (mem_wr_en)
                valid[fb.fb_src.index] <= 1'b1;
end

// Valid bit sampled in step with the RAM read.
always_ff @(posedge i_clk)
begin
        if (i_reset || i_clear)
                rd_valid <= 1'b0;
        else if (mem_rd_en)
                rd_valid <= valid[i_rd_addr.index];
end

// Entry belongs to the delayed address.
assign tag_match = rd_data.tag == i_rd_addr_del.tag;
assign hit       = rd_valid & tag_match;

// Redirect decision, one cycle after the RAM read.
always_ff @(posedge i_clk)
begin
        if (i_reset || i_clear)
        begin
                o_clear_from_btb <= 1'b0;
                o_branch_state   <= bp_pred_pkg::SNT;
        end
        else if (!i_stall)
        begin
                o_clear_from_btb <= hit & bp_pred_pkg::is_taken(rd_data.state);
                // Misses report not taken.
                o_branch_state   <= hit ? rd_data.state : bp_pred_pkg::SNT;
        end
end

// Predicted target. Meaningful only with the pulse.
always_ff @(posedge i_clk)
begin
        if (!i_stall)
                o_pc_from_btb <= rd_data.target;
end

// Resolver never reports both outcomes at once.
a_fb_onehot: assert property (@(posedge i_clk) disable iff (i_reset)
        !(fb.fb_ok && fb.fb_nok));

// A held stall never raises a new redirect.
a_no_redirect_in_stall: assert property (@(posedge i_clk) disable iff (i_reset)
        i_stall |=> !$rose(o_clear_from_btb));

endmodule

`default_nettype wire

//--- src/btb_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_cfg.svh"

// Simple dual port RAM for the branch target buffer.
// One write port, one registered read port.
module btb_ram #(
        parameter int WIDTH = bp_addr_pkg::ENTRY_W
) (
        input  logic                          i_clk,
        input  logic                          i_wr_en,
        input  logic [bp_addr_pkg::IDX_W-1:0] i_wr_addr,
        input  logic [WIDTH-1:0]              i_wr_data,
        input  logic                          i_rd_en,
        input  logic [bp_addr_pkg::IDX_W-1:0] i_rd_addr,
        output logic [WIDTH-1:0]              o_rd_data
);

// Storage array.
logic [WIDTH-1:0] mem [`BP_ENTRIES];

// Write port.
always_ff @(posedge i_clk)
begin
        if (i_wr_en)
                mem[i_wr_addr] <= i_wr_data;
end

// Read port. Returns old data when hitting the write address.
always_ff @(posedge i_clk)
begin
        if (i_rd_en)
                o_rd_data <= mem[i_rd_addr];
end

endmodule

`default_nettype wire

//--- src/pc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_cfg.svh"

// Fetch address generator.
// Resolver redirect beats buffer redirect beats sequential fetch.
module pc_sequencer (
        input  logic               i_clk,
        input  logic               i_reset,
        input  logic               i_stall,

        // Predicted redirect from the buffer.
        input  logic               i_btb_redirect,
        input  bp_addr_pkg::addr_t i_btb_target,

        // Corrective redirect from the resolver.
        input  logic               i_res_redirect,
        input  bp_addr_pkg::addr_t i_res_target,

        // Current fetch address and its one cycle old copy.
        output bp_addr_pkg::addr_t o_rd_addr,
        output bp_addr_pkg::addr_t o_rd_addr_del
);

localparam bp_addr_pkg::addr_t STEP = `BP_STEP;

logic               res_pend;
bp_addr_pkg::addr_t res_pend_target;
logic               res_sel;
bp_addr_pkg::addr_t res_target;
bp_addr_pkg::addr_t pc_nxt;

// Resolver pulses are not frozen, so park one that lands in a stall.
always_ff @(posedge i_clk)
begin
        if (i_reset)
                res_pend <= 1'b0;
        else if (i_stall && i_res_redirect)
                res_pend <= 1'b1;
        else if (!i_stall)
                res_pend <= 1'b0;
end

always_ff @(posedge i_clk)
begin
        if (i_stall && i_res_redirect)
                res_pend_target <= i_res_target;
end

// Fresh pulse overrides a parked one.
assign res_sel    = i_res_redirect | res_pend;
assign res_target = i_res_redirect ? i_res_target : res_pend_target;

// Next address by priority.
always_comb
begin
        if (res_sel)
                pc_nxt = res_target;
        else if (i_btb_redirect)
                pc_nxt = i_btb_target;
        else
                pc_nxt = bp_addr_pkg::addr_t'(o_rd_addr + STEP);
end

// Fetch PC and delayed PC advance together.
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_rd_addr     <= '0;
                o_rd_addr_del <= '0;
        end
        else if (!i_stall)
        begin
                o_rd_addr     <= pc_nxt;
                o_rd_addr_del <= o_rd_addr;
        end
end

// Halfword aligned fetch only.
a_pc_aligned: assert property (@(posedge i_clk) disable iff (i_reset)
        o_rd_addr.offset == 1'b0);

endmodule

`default_nettype wire
